//--- pipe_cpu.f
cpu_pkg.sv
run_control.sv
fetch_stage.sv
decode_stage.sv
hazard_forward_unit.sv
execute_stage.sv
memory_stage.sv
pipe_cpu_top.sv
tb_clock_gen.sv
pipe_cpu_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal
TOP       := pipe_cpu_tb
FILELIST  := pipe_cpu.f
LOG       := sim.log
FAIL_MSG  := Test failures found

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- pipe_cpu_tb.sv
`timescale 1ns/10ps
module pipe_cpu_tb import cpu_pkg::*; ();
	localparam int prog_total = 1 + 10 + 7 + 10 + 6 + 4; // words over all programs
	localparam int run_limit = prog_total * 4 + 200;

	logic clock, rst;
	logic load_valid, start, halted, dbg_sel;
	logic [pc_w-1:0] load_addr, dbg_addr;
	logic [data_w-1:0] load_data, dbg_data;
	run_state_t state;

	logic [31:0] prog [$];
	logic [31:0] lfsr_state;
	logic [31:0] mreg [32]; // reference register file
	logic [31:0] mmem [64];
	logic mmem_set [64]; // words the reference has written
	logic waiting;
	int wait_cycles = 0;
	int errors, checks;

	tb_clock_gen u_clock_gen (.clock, .rst);

	pipe_cpu_top u_dut (.clock, .rst, .load_valid, .load_addr, .load_data, .start, .halted,
		.state, .dbg_sel, .dbg_addr, .dbg_data);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [15:0] rand16();
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] r_op(input alu_op_t f, input int rd, input int rs, input int rt);
		return {ALU_R, 5'(rs), 5'(rt), 5'(rd), 8'h00, f};
	endfunction

	function automatic logic [31:0] i_op(input op_t op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// sequential ISA model stepping one instruction at a time
	task automatic model_run();
		logic [pc_w-1:0] pc;
		logic [31:0] ins, a, b, imm, res;
		logic [5:0] ea;
		logic done;
		pc = '0;
		done = 1'b0;
		for (int n = 0; n < 64 && !done; n++) begin
			ins = int'(pc) < prog.size() ? prog[pc] : {HALT, 26'd0};
			a = mreg[ins[25:21]];
			b = mreg[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea = 6'(a + imm);
			pc = pc + 6'd1;
			case (ins[31:26])
				ALU_R: begin
					case (ins[2:0])
						3'd1: res = a - b;
						3'd2: res = a & b;
						3'd3: res = a | b;
						3'd4: res = {31'd0, $signed(a) < $signed(b)};
						default: res = a + b;
					endcase
					if (ins[15:11] != 5'd0)
						mreg[ins[15:11]] = res;
				end
				ADDI: begin
					if (ins[20:16] != 5'd0)
						mreg[ins[20:16]] = a + imm;
				end
				LW: begin
					if (ins[20:16] != 5'd0)
						mreg[ins[20:16]] = mmem[ea];
				end
				SW: begin
					mmem[ea] = b;
					mmem_set[ea] = 1'b1;
				end
				BEQ: begin
					if (a == b)
						pc = pc + imm[5:0]; // relative to the next word
				end
				J: pc = ins[5:0];
				default: done = 1'b1; // HALT
			endcase
		end
	endtask

	task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
		input string what, input int idx);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s %0d read %h, expected %h", $time, what, idx, got, exp);
		end
	endtask

	task automatic verify_run_state(input run_state_t exp, input string what);
		checks++;
		if (state !== exp) begin
			errors++;
			$display("[FAIL] %0t: %s run state %0d, expected %0d", $time, what, state, exp);
		end
	endtask

	task automatic dbg_read(input logic sel, input int addr, output logic [31:0] val);
		@(posedge clock);
		dbg_sel <= sel;
		dbg_addr <= 6'(addr);
		@(negedge clock);
		val = dbg_data; // settled half a cycle later
	endtask

	task automatic check_state(input string name);
		logic [31:0] got;
		for (int r = 0; r < 32; r++) begin
			dbg_read(1'b0, r, got);
			compare_word(got, mreg[r], {name, ": reg"}, r);
		end
		for (int m = 0; m < 64; m++) begin
			if (mmem_set[m]) begin
				dbg_read(1'b1, m, got);
				compare_word(got, mmem[m], {name, ": mem"}, m);
			end
		end
	endtask

	// load the image, start, wait for halted and compare with the model
	task automatic run_program(input string name);
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clock);
			load_valid <= 1'b1;
			load_addr <= 6'(i);
			load_data <= prog[i];
		end
		@(posedge clock);
		load_valid <= 1'b0;
		start <= 1'b1;
		@(negedge clock);
		verify_run_state(LOAD, {name, ": loading"});
		@(posedge clock);
		start <= 1'b0;
		@(negedge clock);
		verify_run_state(RUN, {name, ": started"});
		waiting = 1'b1;
		while (!halted)
			@(negedge clock);
		waiting = 1'b0;
		model_run();
		check_state(name);
	endtask

	task automatic halt_only();
		logic [31:0] got;
		@(negedge clock);
		checks++;
		if (halted !== 1'b0) begin
			errors++;
			$display("[FAIL] %0t: halted is high right after reset", $time);
		end
		verify_run_state(IDLE, "after reset:");
		dbg_read(1'b1, 5, got);
		compare_word(got, 32'd0, "idle dbg_data", 5);
		prog.delete();
		prog.push_back({HALT, 26'd0});
		run_program("halt only");
	endtask

	task automatic alu_chain();
		prog.delete();
		prog.push_back(i_op(ADDI, 0, 1, rand16()));
		prog.push_back(i_op(ADDI, 1, 2, rand16())); // r1 from EX/MEM
		prog.push_back(r_op(ADD, 3, 1, 2)); // r1 from MEM/WB and r2 from EX/MEM
		prog.push_back(r_op(SUB, 4, 3, 1));
		prog.push_back(r_op(AND, 5, 4, 3));
		prog.push_back(r_op(OR, 6, 5, 2));
		prog.push_back(r_op(SLT, 7, 6, 4));
		prog.push_back(r_op(SLT, 8, 4, 6));
		prog.push_back(r_op(ADD, 9, 7, 8));
		prog.push_back({HALT, 26'd0});
		run_program("alu chain");
	endtask

	task automatic load_use();
		prog.delete();
		prog.push_back(i_op(ADDI, 0, 10, rand16()));
		prog.push_back(i_op(ADDI, 0, 11, 16'd5));
		prog.push_back(i_op(SW, 11, 10, 16'd3)); // mem[8]
		prog.push_back(i_op(LW, 11, 12, 16'd3));
		prog.push_back(r_op(ADD, 13, 12, 10)); // needs the one-cycle stall
		prog.push_back(i_op(SW, 11, 13, 16'd4));
		prog.push_back({HALT, 26'd0});
		run_program("load use");
	endtask

	task automatic branch_and_jump();
		prog.delete();
		prog.push_back(i_op(ADDI, 0, 14, 16'd7));
		prog.push_back(i_op(ADDI, 0, 15, 16'd7));
		prog.push_back(i_op(BEQ, 14, 15, 16'd2)); // taken to word 5
		prog.push_back(i_op(ADDI, 0, 20, 16'd1)); // markers
		prog.push_back(i_op(ADDI, 0, 21, 16'd1));
		prog.push_back(i_op(ADDI, 0, 16, rand16()));
		prog.push_back({J, 26'd8});
		prog.push_back(i_op(ADDI, 0, 22, 16'd1));
		prog.push_back(i_op(ADDI, 16, 17, 16'd1));
		prog.push_back({HALT, 26'd0});
		run_program("branch jump");
	endtask

	task automatic beq_not_taken();
		prog.delete();
		prog.push_back(i_op(ADDI, 0, 18, 16'd3));
		prog.push_back(i_op(BEQ, 18, 0, 16'd1));
		prog.push_back(i_op(ADDI, 0, 19, rand16()));
		prog.push_back(i_op(ADDI, 0, 0, rand16())); // write to r0 is dropped
		prog.push_back(r_op(ADD, 23, 0, 19));
		prog.push_back({HALT, 26'd0});
		run_program("beq not taken");
	endtask

	task automatic reload_restart();
		prog.delete();
		prog.push_back(i_op(ADDI, 0, 1, rand16()));
		prog.push_back(i_op(ADDI, 0, 24, 16'd9));
		prog.push_back(i_op(SW, 24, 1, 16'd0)); // mem[8] is left alone
		prog.push_back({HALT, 26'd0});
		run_program("reload");
	endtask

	always @(posedge clock) begin
		if (waiting) begin
			wait_cycles <= wait_cycles + 1;
			if (wait_cycles >= run_limit) begin
				$display("timeout: DUT did not halt within %0d run cycles", run_limit);
				$display("Test failures found");
				$finish;
			end
		end
	end

	initial begin
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		start = 1'b0;
		dbg_sel = 1'b0;
		dbg_addr = '0;
		waiting = 1'b0;
		errors = 0;
		checks = 0;
		lfsr_state = 32'h75db72b2;
		for (int i = 0; i < 64; i++) begin
			mmem[i] = '0;
			mmem_set[i] = 1'b0;
		end
		for (int r = 0; r < 32; r++)
			mreg[r] = '0;
		@(negedge rst);
		halt_only();
		alu_chain();
		load_use();
		branch_and_jump();
		beq_not_taken();
		reload_restart();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps
module tb_clock_gen (
	output logic clock,
	output logic rst
);
	localparam int reset_cycles = 8;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

//--- pipe_cpu_top.sv
`timescale 1ns/10ps
module pipe_cpu_top import cpu_pkg::*; #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input logic clock,
	input logic rst,
	input logic load_valid,
	input logic [pc_w-1:0] load_addr,
	input logic [data_w-1:0] load_data,
	input logic start,
	output logic halted,
	output run_state_t state,
	input logic dbg_sel, // 0 register file, 1 data memory
	input logic [pc_w-1:0] dbg_addr,
	output logic [data_w-1:0] dbg_data
);
	logic run_en, pipe_clear, halt_retired, load_we;
	logic stall, redirect, stop_fetch;
	logic [pc_w-1:0] redirect_pc;
	logic [reg_addr_w-1:0] rs_fd, rt_fd;
	logic [data_w-1:0] dbg_reg_data, dbg_mem_data;
	fwd_sel_t fwd_a, fwd_b;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	wb_t wb;

	assign load_we = load_valid && state != RUN; // no program writes while running
	assign halted = state == HALTED;
	assign dbg_data = !halted ? '0 : dbg_sel ? dbg_mem_data : dbg_reg_data;

	run_control u_run_control (.clock, .rst, .load_valid, .start, .halt_retired,
		.run_en, .pipe_clear, .state);

	fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (.clock, .rst, .run_en, .pipe_clear,
		.stall, .redirect, .redirect_pc, .stop_fetch, .load_valid(load_we),
		.load_addr, .load_data, .if_id);

	decode_stage u_decode (.clock, .rst, .run_en, .pipe_clear, .stall, .redirect, .if_id,
		.wb, .dbg_reg_addr(dbg_addr[reg_addr_w-1:0]), .dbg_reg_data, .id_ex,
		.rs_fd, .rt_fd, .stop_fetch);

	hazard_forward_unit u_hazard (.id_ex, .ex_mem, .mem_wb, .rs_fd, .rt_fd,
		.stall, .fwd_a, .fwd_b);

	execute_stage u_execute (.clock, .rst, .run_en, .pipe_clear, .id_ex, .fwd_a, .fwd_b,
		.fwd_ex_mem(ex_mem.result), .fwd_mem_wb(mem_wb.wb_val), .ex_mem,
		.redirect, .redirect_pc);

	memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (.clock, .rst, .run_en, .pipe_clear,
		.ex_mem, .dbg_mem_addr(dbg_addr), .dbg_mem_data, .mem_wb, .wb, .halt_retired);

endmodule

//--- memory_stage.sv
`timescale 1ns/10ps
module memory_stage import cpu_pkg::*; #(
	parameter int DMEM_DEPTH = 64
) (
	input logic clock,
	input logic rst,
	input logic run_en,
	input logic pipe_clear,
	input ex_mem_t ex_mem,
	input logic [pc_w-1:0] dbg_mem_addr,
	output logic [data_w-1:0] dbg_mem_data,
	output mem_wb_t mem_wb,
	output wb_t wb,
	output logic halt_retired
);
	localparam int aw = $clog2(DMEM_DEPTH);

	logic [data_w-1:0] dmem [DMEM_DEPTH];
	logic [aw-1:0] addr;
	logic [data_w-1:0] load_data;

	assign addr = ex_mem.result[aw-1:0]; // word address from the ALU
	assign load_data = dmem[addr];
	assign dbg_mem_data = dmem[aw'(dbg_mem_addr)];

	always_ff @(posedge clock) begin
		if (run_en && ex_mem.valid && ex_mem.mem_write)
			dmem[addr] <= ex_mem.store_val;
	end

	always_ff @(posedge clock) begin
		if (rst || pipe_clear) begin
			mem_wb.valid <= 1'b0;
		end else if (run_en) begin
			mem_wb.wb_val <= ex_mem.mem_to_reg ? load_data : ex_mem.result;
			mem_wb.dst <= ex_mem.dst;
			mem_wb.reg_write <= ex_mem.reg_write;
			mem_wb.halt <= ex_mem.halt;
			mem_wb.valid <= ex_mem.valid;
		end
	end

	assign wb.en = mem_wb.valid && mem_wb.reg_write;
	assign wb.addr = mem_wb.dst;
	assign wb.data = mem_wb.wb_val;
	assign halt_retired = mem_wb.valid && mem_wb.halt;

endmodule

//--- execute_stage.sv
`timescale 1ns/10ps
module execute_stage import cpu_pkg::*; (
	input logic clock,
	input logic rst,
	input logic run_en,
	input logic pipe_clear,
	input id_ex_t id_ex,
	input fwd_sel_t fwd_a,
	input fwd_sel_t fwd_b,
	input logic [data_w-1:0] fwd_ex_mem,
	input logic [data_w-1:0] fwd_mem_wb,
	output ex_mem_t ex_mem,
	output logic redirect,
	output logic [pc_w-1:0] redirect_pc
);
	logic [data_w-1:0] op_a, reg_b, op_b, result;

	function automatic logic [data_w-1:0] pick(
		input fwd_sel_t sel,
		input logic [data_w-1:0] reg_val,
		input logic [data_w-1:0] from_ex_mem,
		input logic [data_w-1:0] from_mem_wb
	);
		case (sel)
			FWD_EX_MEM: return from_ex_mem;
			FWD_MEM_WB: return from_mem_wb;
			default: return reg_val;
		endcase
	endfunction

	assign op_a = pick(fwd_a, id_ex.rd1, fwd_ex_mem, fwd_mem_wb);
	assign reg_b = pick(fwd_b, id_ex.rd2, fwd_ex_mem, fwd_mem_wb);
	assign op_b = id_ex.alu_src ? id_ex.imm : reg_b;

	always_comb begin
		case (id_ex.alu_op)
			SUB: result = op_a - op_b;
			AND: result = op_a & op_b;
			OR: result = op_a | op_b;
			SLT: result = {{(data_w-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			default: result = op_a + op_b;
		endcase
	end

	// BEQ compares the forwarded register values directly
	assign redirect = id_ex.valid && (id_ex.jump || (id_ex.branch && op_a == reg_b));
	assign redirect_pc = id_ex.jump ? id_ex.imm[pc_w-1:0]
		: id_ex.pc + pc_w'(1) + id_ex.imm[pc_w-1:0];

	always_ff @(posedge clock) begin
		if (rst || pipe_clear) begin
			ex_mem.valid <= 1'b0;
		end else if (run_en) begin
			ex_mem.result <= result;
			ex_mem.store_val <= reg_b;
			ex_mem.dst <= id_ex.dst;
			ex_mem.mem_read <= id_ex.mem_read;
			ex_mem.mem_write <= id_ex.mem_write;
			ex_mem.mem_to_reg <= id_ex.mem_to_reg;
			ex_mem.reg_write <= id_ex.reg_write;
			ex_mem.halt <= id_ex.halt;
			ex_mem.valid <= id_ex.valid;
		end
	end

endmodule

//--- hazard_forward_unit.sv
`timescale 1ns/10ps
module hazard_forward_unit import cpu_pkg::*; (
	input id_ex_t id_ex,
	input ex_mem_t ex_mem,
	input mem_wb_t mem_wb,
	input logic [reg_addr_w-1:0] rs_fd,
	input logic [reg_addr_w-1:0] rt_fd,
	output logic stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);
	logic ex_mem_wr, mem_wb_wr;

	function automatic fwd_sel_t fwd_src(
		input logic [reg_addr_w-1:0] src,
		input logic xm_wr,
		input logic [reg_addr_w-1:0] xm_dst,
		input logic mw_wr,
		input logic [reg_addr_w-1:0] mw_dst
	);
		if (xm_wr && xm_dst == src)
			return FWD_EX_MEM; // newest value wins
		else if (mw_wr && mw_dst == src)
			return FWD_MEM_WB;
		return FWD_REG;
	endfunction

	// a load in EX/MEM only has its address, the stall covers that case
	assign ex_mem_wr = ex_mem.valid && ex_mem.reg_write && !ex_mem.mem_read && ex_mem.dst != '0;
	assign mem_wb_wr = mem_wb.valid && mem_wb.reg_write && mem_wb.dst != '0;

	assign fwd_a = fwd_src(id_ex.rs, ex_mem_wr, ex_mem.dst, mem_wb_wr, mem_wb.dst);
	assign fwd_b = fwd_src(id_ex.rt, ex_mem_wr, ex_mem.dst, mem_wb_wr, mem_wb.dst);

	assign stall = id_ex.valid && id_ex.mem_read && id_ex.dst != '0
		&& (id_ex.dst == rs_fd || id_ex.dst == rt_fd);

endmodule

//--- decode_stage.sv
`timescale 1ns/10ps
module decode_stage import cpu_pkg::*; (
	input logic clock,
	input logic rst,
	input logic run_en,
	input logic pipe_clear,
	input logic stall,
	input logic redirect,
	input if_id_t if_id,
	input wb_t wb,
	input logic [reg_addr_w-1:0] dbg_reg_addr,
	output logic [data_w-1:0] dbg_reg_data,
	output id_ex_t id_ex,
	output logic [reg_addr_w-1:0] rs_fd,
	output logic [reg_addr_w-1:0] rt_fd,
	output logic stop_fetch
);
	logic [data_w-1:0] regs [32];
	op_t op;
	logic [reg_addr_w-1:0] rs, rt, rd;
	id_ex_t dec;

	// write-then-read: a same-cycle write is seen by the read
	function automatic logic [data_w-1:0] rf_read(input logic [reg_addr_w-1:0] a);
		if (a == '0)
			return '0;
		else if (wb.en && wb.addr == a)
			return wb.data;
		return regs[a];
	endfunction

	assign op = op_t'(if_id.instr[31:26]);
	assign rs = if_id.instr[25:21];
	assign rt = if_id.instr[20:16];
	assign rd = if_id.instr[15:11];
	assign rs_fd = if_id.valid ? rs : '0; // nothing to hazard on when empty
	assign rt_fd = if_id.valid ? rt : '0;
	assign stop_fetch = if_id.valid && op == HALT && !redirect;
	assign dbg_reg_data = regs[dbg_reg_addr];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.en && wb.addr != '0) begin
			regs[wb.addr] <= wb.data;
		end
	end

	always_comb begin
		dec = '0;
		dec.rd1 = rf_read(rs);
		dec.rd2 = rf_read(rt);
		dec.imm = {{(data_w-16){if_id.instr[15]}}, if_id.instr[15:0]};
		dec.rs = rs;
		dec.rt = rt;
		dec.pc = if_id.pc;
		dec.valid = if_id.valid && !stall && !redirect; // bubble
		case (op)
			ALU_R: begin
				dec.alu_op = alu_op_t'(if_id.instr[2:0]);
				dec.reg_write = 1'b1;
				dec.dst = rd;
			end
			ADDI: begin
				dec.alu_src = 1'b1;
				dec.reg_write = 1'b1;
				dec.dst = rt;
			end
			LW: begin
				dec.alu_src = 1'b1;
				dec.mem_read = 1'b1;
				dec.mem_to_reg = 1'b1;
				dec.reg_write = 1'b1;
				dec.dst = rt;
			end
			SW: begin
				dec.alu_src = 1'b1;
				dec.mem_write = 1'b1;
			end
			BEQ: dec.branch = 1'b1;
			J: begin
				dec.jump = 1'b1;
				dec.imm = {{(data_w-26){1'b0}}, if_id.instr[25:0]}; // absolute target
			end
			HALT: dec.halt = 1'b1;
			default: ; // unknown opcode runs as a nop
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst || pipe_clear)
			id_ex.valid <= 1'b0;
		else if (run_en)
			id_ex <= dec;
	end

endmodule

//--- fetch_stage.sv
`timescale 1ns/10ps
module fetch_stage import cpu_pkg::*; #(
	parameter int IMEM_DEPTH = 64
) (
	input logic clock,
	input logic rst,
	input logic run_en,
	input logic pipe_clear,
	input logic stall,
	input logic redirect,
	input logic [pc_w-1:0] redirect_pc,
	input logic stop_fetch,
	input logic load_valid,
	input logic [pc_w-1:0] load_addr,
	input logic [data_w-1:0] load_data,
	output if_id_t if_id
);
	localparam int aw = $clog2(IMEM_DEPTH);

	logic [data_w-1:0] imem [IMEM_DEPTH];
	logic [pc_w-1:0] pc;
	logic stopped; // HALT seen in decode, no more fetching

	always_ff @(posedge clock) begin
		if (load_valid)
			imem[aw'(load_addr)] <= load_data;
	end

	always_ff @(posedge clock) begin
		if (rst || pipe_clear) begin
			pc <= '0;
			if_id.valid <= 1'b0;
			stopped <= 1'b0;
		end else if (run_en) begin
			if (redirect) begin
				pc <= redirect_pc;
				if_id.valid <= 1'b0; // squash the wrong-path fetch
			end else if (!stall) begin
				if (stopped || stop_fetch) begin
					if_id.valid <= 1'b0;
				end else begin
					if_id.instr <= imem[aw'(pc)];
					if_id.pc <= pc;
					if_id.valid <= 1'b1;
					pc <= pc + 1'b1;
				end
			end
			if (stop_fetch)
				stopped <= 1'b1;
		end
	end

endmodule

//--- run_control.sv
`timescale 1ns/10ps
module run_control import cpu_pkg::*; (
	input logic clock,
	input logic rst,
	input logic load_valid,
	input logic start,
	input logic halt_retired,
	output logic run_en,
	output logic pipe_clear,
	output run_state_t state
);
	run_state_t state_next;

	always_ff @(posedge clock) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE, LOAD, HALTED: begin
				if (start)
					state_next = RUN; // start wins over a load word
				else if (load_valid)
					state_next = LOAD;
			end
			RUN: begin
				if (halt_retired)
					state_next = HALTED;
			end
			default: state_next = IDLE;
		endcase
	end

	assign run_en = state == RUN;
	// restarts pc and valid bits on the edge that enters RUN
	assign pipe_clear = start && state != RUN;

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	localparam int data_w = 32;
	localparam int reg_addr_w = 5;
	localparam int pc_w = 6; // word address, 64 words per memory

	// opcode field, instr[31:26]
	typedef enum logic [5:0] {
		ALU_R = 6'h00,
		J     = 6'h02,
		BEQ   = 6'h04,
		ADDI  = 6'h08,
		LW    = 6'h23,
		SW    = 6'h2b,
		HALT  = 6'h3f
	} op_t;

	// also the funct encoding of ALU_R, instr[2:0]
	typedef enum logic [2:0] {ADD = 3'd0, SUB, AND, OR, SLT} alu_op_t;

	typedef enum logic [1:0] {IDLE, LOAD, RUN, HALTED} run_state_t;

	typedef enum logic [1:0] {FWD_REG, FWD_EX_MEM, FWD_MEM_WB} fwd_sel_t;

	typedef struct packed {
		logic [data_w-1:0] instr;
		logic [pc_w-1:0] pc;
		logic valid;
	} if_id_t;

	typedef struct packed {
		logic [data_w-1:0] rd1, rd2, imm;
		logic [reg_addr_w-1:0] rs, rt, dst;
		alu_op_t alu_op;
		logic alu_src, mem_read, mem_write, mem_to_reg, reg_write;
		logic branch, jump, halt;
		logic [pc_w-1:0] pc;
		logic valid;
	} id_ex_t;

	typedef struct packed {
		logic [data_w-1:0] result, store_val;
		logic [reg_addr_w-1:0] dst;
		logic mem_read, mem_write, mem_to_reg, reg_write, halt, valid;
	} ex_mem_t;

	typedef struct packed {
		logic [data_w-1:0] wb_val;
		logic [reg_addr_w-1:0] dst;
		logic reg_write, halt, valid;
	} mem_wb_t;

	typedef struct packed {
		logic en;
		logic [reg_addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} wb_t;

endpackage
